// File: design/lsu_cfg.svh
// -------------------------------------------------------------------
// Load-store unit configuration
// Queue depth and field widths shared by design and testbench
// -------------------------------------------------------------------
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Number of queue slots, must be a power of two
`define LSU_QUEUE_DEPTH 4

// Instruction tag width
`define LSU_TAG_WIDTH 10

// Address and data word widths
`define LSU_ADDR_WIDTH 64
`define LSU_DATA_WIDTH 64

`endif

// File: design/lsu_pkg.sv
// -------------------------------------------------------------------
// LSU queue types
// Tag, address, data, slot index and the slot and operation encodings
// -------------------------------------------------------------------
`include "lsu_cfg.svh"

package lsu_pkg;

  // Instruction tag from the processor
  typedef logic [`LSU_TAG_WIDTH-1:0] tag_t;

  // Effective address and data word
  typedef logic [`LSU_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`LSU_DATA_WIDTH-1:0] data_t;

  // Slot position in the ring
  typedef logic [$clog2(`LSU_QUEUE_DEPTH)-1:0] slot_idx_t;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } op_e;

  // Life of one slot, from allocation to retire
  typedef enum logic [2:0] {
    SLOT_FREE,
    SLOT_WAIT_ADDR,
    SLOT_READY,
    SLOT_ISSUED,
    SLOT_DONE
  } slot_state_e;

endpackage : lsu_pkg

// File: design/l1d_pkg.sv
// -------------------------------------------------------------------
// L1D port types
// Request kind and the request FSM states
// -------------------------------------------------------------------
package l1d_pkg;

  // Meaning of the write enable on the request
  typedef enum logic {
    L1D_READ,
    L1D_WRITE
  } l1d_req_kind_e;

  // One request in flight at a time
  typedef enum logic [1:0] {
    L1D_IDLE,
    L1D_REQ,
    L1D_WAIT_RESP
  } l1d_state_e;

endpackage : l1d_pkg

// File: design/lsu_alloc.sv
// -------------------------------------------------------------------
// LSU allocator
// Ring pointers, in-order slot allocation and head advance
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_alloc (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         instr_valid,
  input  logic                         instr_is_store,
  input  lsu_pkg::tag_t                instr_tag,
  input  lsu_pkg::slot_state_e         slot_state [`LSU_QUEUE_DEPTH],
  input  logic [`LSU_QUEUE_DEPTH-1:0]  retire_en,
  output logic                         instr_ready,
  output logic                         data_ready,
  output logic [`LSU_QUEUE_DEPTH-1:0]  alloc_en,
  output lsu_pkg::slot_idx_t           head_idx
);
  import lsu_pkg::*;

  slot_idx_t                         tail_idx;
  // Occupied ring positions, freed holes included
  logic [$clog2(`LSU_QUEUE_DEPTH):0] count;
  logic                              push;
  logic                              pop;

  assign instr_ready = (count < `LSU_QUEUE_DEPTH);
  assign push        = instr_valid && instr_ready;

  // Head leaves a slot retiring now or one freed out of order earlier
  assign pop = (count != '0) &&
               (retire_en[head_idx] || (slot_state[head_idx] == SLOT_FREE));

  always_comb begin
    alloc_en           = '0;
    alloc_en[tail_idx] = push;
    data_ready         = 1'b0;
    for (int i = 0; i < `LSU_QUEUE_DEPTH; i++) begin
      if (slot_state[i] == SLOT_WAIT_ADDR) begin
        data_ready = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      head_idx <= '0;
      tail_idx <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        tail_idx <= tail_idx + 1'b1;
      end
      if (pop) begin
        head_idx <= head_idx + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // New access lands in a slot already passed by the head
  a_alloc_free: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    push |-> (slot_state[tail_idx] == SLOT_FREE))
    else $error("allocation into a busy slot");

  // Processor holds a stalled instruction
  a_instr_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (instr_valid && !instr_ready) |=>
      instr_valid && $stable(instr_tag) && $stable(instr_is_store))
    else $error("instruction dropped while stalled");

endmodule : lsu_alloc

// File: design/lsu_slot.sv
// -------------------------------------------------------------------
// LSU queue slot
// State, tag, operation, address and value of one access
// -------------------------------------------------------------------
`timescale 1ns/1ps

module lsu_slot (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 alloc_en,
  input  logic                 instr_is_store,
  input  lsu_pkg::tag_t        instr_tag,
  input  logic                 data_valid,
  input  lsu_pkg::tag_t        data_tag,
  input  lsu_pkg::addr_t       data_addr,
  input  lsu_pkg::data_t       data_value,
  input  logic                 fwd_en,
  input  lsu_pkg::data_t       fwd_value,
  input  logic                 issue_mark,
  input  logic                 retire_en,
  input  logic                 resp_valid,
  input  lsu_pkg::tag_t        resp_tag,
  input  lsu_pkg::data_t       resp_data,
  output lsu_pkg::slot_state_e state,
  output lsu_pkg::op_e         op,
  output lsu_pkg::tag_t        tag,
  output lsu_pkg::addr_t       addr,
  output lsu_pkg::data_t       value
);
  import lsu_pkg::*;

  logic data_hit;
  logic resp_hit;

  // Address and response are both matched by tag
  assign data_hit = data_valid && (data_tag == tag);
  assign resp_hit = resp_valid && (resp_tag == tag);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state <= SLOT_FREE;
    end else begin
      case (state)
        SLOT_FREE:      if (alloc_en) state <= SLOT_WAIT_ADDR;
        SLOT_WAIT_ADDR: if (data_hit) state <= SLOT_READY;
        SLOT_READY: begin
          // Forwarded load is finished without the cache
          if (fwd_en) begin
            state <= SLOT_DONE;
          end else if (issue_mark) begin
            state <= SLOT_ISSUED;
          end
        end
        SLOT_ISSUED:    if (resp_hit) state <= SLOT_DONE;
        SLOT_DONE:      if (retire_en) state <= SLOT_FREE;
        default:        state <= SLOT_FREE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc_en) begin
      op  <= instr_is_store ? OP_STORE : OP_LOAD;
      tag <= instr_tag;
    end
    // Store data comes with the address
    if ((state == SLOT_WAIT_ADDR) && data_hit) begin
      addr <= data_addr;
      if (op == OP_STORE) begin
        value <= data_value;
      end
    end
    if ((state == SLOT_READY) && fwd_en) begin
      value <= fwd_value;
    end
    // Load data from the cache, a store keeps its own value
    if ((state == SLOT_ISSUED) && resp_hit && (op == OP_LOAD)) begin
      value <= resp_data;
    end
  end

  // Cache answers only the access this slot has sent
  a_resp_issued: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (resp_hit && (state != SLOT_FREE)) |-> (state == SLOT_ISSUED))
    else $error("response for tag %0h outside ISSUED", tag);

endmodule : lsu_slot

// File: design/lsu_select.sv
// -------------------------------------------------------------------
// LSU selector
// Age order, store-to-load forwarding, issue choice and completion
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_select (
  input  logic                          clk_in,
  input  logic                          rst_N_in,
  input  lsu_pkg::slot_idx_t            head_idx,
  input  lsu_pkg::slot_state_e          state [`LSU_QUEUE_DEPTH],
  input  lsu_pkg::op_e                  op    [`LSU_QUEUE_DEPTH],
  input  lsu_pkg::tag_t                 tag   [`LSU_QUEUE_DEPTH],
  input  lsu_pkg::addr_t                addr  [`LSU_QUEUE_DEPTH],
  input  lsu_pkg::data_t                value [`LSU_QUEUE_DEPTH],
  input  logic                          issue_ready,
  output logic [`LSU_QUEUE_DEPTH-1:0]   fwd_en,
  output lsu_pkg::data_t                fwd_value,
  output logic [`LSU_QUEUE_DEPTH-1:0]   issue_mark,
  output logic [`LSU_QUEUE_DEPTH-1:0]   retire_en,
  output logic                          issue_valid,
  output l1d_pkg::l1d_req_kind_e        issue_kind,
  output lsu_pkg::addr_t                issue_addr,
  output lsu_pkg::data_t                issue_data,
  output lsu_pkg::tag_t                 issue_tag,
  output logic                          cpl_valid,
  output lsu_pkg::tag_t                 cpl_tag,
  output lsu_pkg::data_t                cpl_value
);
  import lsu_pkg::*;
  import l1d_pkg::*;

  // Slot at each age, age 0 is the head
  slot_idx_t age_slot [`LSU_QUEUE_DEPTH];
  slot_idx_t iss_idx;
  slot_idx_t cpl_idx;
  logic      cpl_found;

  for (genvar k = 0; k < `LSU_QUEUE_DEPTH; k++) begin : g_age
    assign age_slot[k] = head_idx + slot_idx_t'(k);
  end

  // -------------------------------------------------------------------
  // Forwarding and issue
  // -------------------------------------------------------------------
  always_comb begin
    slot_idx_t ld;
    slot_idx_t st;
    logic      blocked;
    logic      hit;
    data_t     hit_val;
    logic      fwd_found;
    logic      ld_found;
    slot_idx_t ld_idx;
    fwd_en    = '0;
    fwd_value = '0;
    fwd_found = 1'b0;
    ld_found  = 1'b0;
    ld_idx    = head_idx;
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      ld      = age_slot[k];
      blocked = 1'b0;
      hit     = 1'b0;
      hit_val = '0;
      // Older stores oldest first, so the last match is the youngest
      for (int m = 0; m < k; m++) begin
        st = age_slot[m];
        if ((op[st] == OP_STORE) && (state[st] == SLOT_WAIT_ADDR)) begin
          blocked = 1'b1;
        end else if ((op[st] == OP_STORE) && (state[st] != SLOT_FREE) &&
                     (addr[st] == addr[ld])) begin
          hit     = 1'b1;
          hit_val = value[st];
        end
      end
      // One forward and one load candidate per cycle, oldest wins
      if ((state[ld] == SLOT_READY) && (op[ld] == OP_LOAD) && !blocked) begin
        if (hit && !fwd_found) begin
          fwd_found  = 1'b1;
          fwd_en[ld] = 1'b1;
          fwd_value  = hit_val;
        end else if (!hit && !ld_found) begin
          ld_found = 1'b1;
          ld_idx   = ld;
        end
      end
    end
    // Loads first, a store only from the head
    if (ld_found) begin
      issue_valid = 1'b1;
      iss_idx     = ld_idx;
    end else begin
      issue_valid = (state[head_idx] == SLOT_READY) && (op[head_idx] == OP_STORE);
      iss_idx     = head_idx;
    end
    issue_mark          = '0;
    issue_mark[iss_idx] = issue_valid && issue_ready;
  end

  assign issue_kind = (op[iss_idx] == OP_STORE) ? L1D_WRITE : L1D_READ;
  assign issue_addr = addr[iss_idx];
  assign issue_data = value[iss_idx];
  assign issue_tag  = tag[iss_idx];

  // -------------------------------------------------------------------
  // Completion, oldest DONE slot retires
  // -------------------------------------------------------------------
  always_comb begin
    cpl_found = 1'b0;
    cpl_idx   = head_idx;
    retire_en = '0;
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      if (!cpl_found && (state[age_slot[k]] == SLOT_DONE)) begin
        cpl_found = 1'b1;
        cpl_idx   = age_slot[k];
      end
    end
    retire_en[cpl_idx] = cpl_found;
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      cpl_valid <= 1'b0;
    end else begin
      cpl_valid <= cpl_found;
    end
  end

  // Stores report zero
  always_ff @(posedge clk_in) begin
    if (cpl_found) begin
      cpl_tag   <= tag[cpl_idx];
      cpl_value <= (op[cpl_idx] == OP_STORE) ? '0 : value[cpl_idx];
    end
  end

endmodule : lsu_select

// File: design/l1d_port.sv
// -------------------------------------------------------------------
// L1D port
// Sends one request to the cache and returns its response
// -------------------------------------------------------------------
`timescale 1ns/1ps

module l1d_port (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  logic                   issue_valid,
  input  l1d_pkg::l1d_req_kind_e issue_kind,
  input  lsu_pkg::addr_t         issue_addr,
  input  lsu_pkg::data_t         issue_data,
  input  lsu_pkg::tag_t          issue_tag,
  input  logic                   l1d_req_ready,
  input  logic                   l1d_resp_valid,
  input  lsu_pkg::tag_t          l1d_resp_tag,
  input  lsu_pkg::data_t         l1d_resp_data,
  output logic                   issue_ready,
  output logic                   l1d_req_valid,
  output lsu_pkg::addr_t         l1d_req_addr,
  output lsu_pkg::data_t         l1d_req_data,
  output l1d_pkg::l1d_req_kind_e l1d_req_we,
  output lsu_pkg::tag_t          l1d_req_tag,
  output logic                   resp_valid,
  output lsu_pkg::tag_t          resp_tag,
  output lsu_pkg::data_t         resp_data
);
  import l1d_pkg::*;

  l1d_state_e state_q;
  l1d_state_e state_d;

  // Only IDLE takes a new access, so one request at most is outstanding
  assign issue_ready   = (state_q == L1D_IDLE);
  assign l1d_req_valid = (state_q == L1D_REQ);

  // Response goes straight to the slots
  assign resp_valid = (state_q == L1D_WAIT_RESP) && l1d_resp_valid;
  assign resp_tag   = l1d_resp_tag;
  assign resp_data  = l1d_resp_data;

  always_comb begin
    state_d = state_q;
    case (state_q)
      L1D_IDLE:      if (issue_valid) state_d = L1D_REQ;
      L1D_REQ:       if (l1d_req_ready) state_d = L1D_WAIT_RESP;
      L1D_WAIT_RESP: if (l1d_resp_valid) state_d = L1D_IDLE;
      default:       state_d = L1D_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= L1D_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields latched once, held through REQ and WAIT_RESP
  always_ff @(posedge clk_in) begin
    if ((state_q == L1D_IDLE) && issue_valid) begin
      l1d_req_addr <= issue_addr;
      l1d_req_data <= issue_data;
      l1d_req_we   <= issue_kind;
      l1d_req_tag  <= issue_tag;
    end
  end

  // Stalled request keeps its fields until the cache takes it
  a_req_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (l1d_req_valid && !l1d_req_ready) |=>
      l1d_req_valid && $stable(l1d_req_addr) && $stable(l1d_req_data) &&
      $stable(l1d_req_we) && $stable(l1d_req_tag))
    else $error("L1D request changed while stalled");

  // Response only while waiting, and for the access that was sent
  a_resp_tag: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_resp_valid |-> (state_q == L1D_WAIT_RESP) && (l1d_resp_tag == l1d_req_tag))
    else $error("unexpected L1D response tag %0h", l1d_resp_tag);

endmodule : l1d_port

// File: design/load_store_unit.sv
// -------------------------------------------------------------------
// Load-store unit top level
// Allocator, slot array, selector and L1D port
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module load_store_unit (
  input  logic           clk_in,
  input  logic           rst_N_in,
  // Instruction port
  input  logic           instr_valid,
  input  lsu_pkg::tag_t  instr_tag,
  input  logic           instr_is_store,
  output logic           instr_ready,
  // Address and data port
  input  logic           data_valid,
  input  lsu_pkg::tag_t  data_tag,
  input  lsu_pkg::addr_t data_addr,
  input  lsu_pkg::data_t data_value,
  output logic           data_ready,
  // Completion port
  output logic           cpl_valid,
  output lsu_pkg::tag_t  cpl_tag,
  output lsu_pkg::data_t cpl_value,
  // L1D request
  output logic           l1d_req_valid,
  output lsu_pkg::addr_t l1d_req_addr,
  output lsu_pkg::data_t l1d_req_data,
  output logic           l1d_req_we,
  output lsu_pkg::tag_t  l1d_req_tag,
  input  logic           l1d_req_ready,
  // L1D response
  input  logic           l1d_resp_valid,
  input  lsu_pkg::tag_t  l1d_resp_tag,
  input  lsu_pkg::data_t l1d_resp_data
);
  import lsu_pkg::*;

  // Slot array contents seen by allocator and selector
  slot_state_e slot_state [`LSU_QUEUE_DEPTH];
  op_e         slot_op    [`LSU_QUEUE_DEPTH];
  tag_t        slot_tag   [`LSU_QUEUE_DEPTH];
  addr_t       slot_addr  [`LSU_QUEUE_DEPTH];
  data_t       slot_value [`LSU_QUEUE_DEPTH];

  // Per-slot controls
  logic [`LSU_QUEUE_DEPTH-1:0] alloc_en;
  logic [`LSU_QUEUE_DEPTH-1:0] fwd_en;
  logic [`LSU_QUEUE_DEPTH-1:0] issue_mark;
  logic [`LSU_QUEUE_DEPTH-1:0] retire_en;
  slot_idx_t                   head_idx;
  data_t                       fwd_value;

  // Selector to L1D port
  logic                   issue_valid;
  logic                   issue_ready;
  l1d_pkg::l1d_req_kind_e issue_kind;
  addr_t                  issue_addr;
  data_t                  issue_data;
  tag_t                   issue_tag;

  // Response broadcast to the slots
  logic  resp_valid;
  tag_t  resp_tag;
  data_t resp_data;

  lsu_alloc u_alloc (.*);

  for (genvar g = 0; g < `LSU_QUEUE_DEPTH; g++) begin : g_slot
    lsu_slot u_slot (
      .alloc_en   (alloc_en[g]),
      .fwd_en     (fwd_en[g]),
      .issue_mark (issue_mark[g]),
      .retire_en  (retire_en[g]),
      .state      (slot_state[g]),
      .op         (slot_op[g]),
      .tag        (slot_tag[g]),
      .addr       (slot_addr[g]),
      .value      (slot_value[g]),
      .*
    );
  end

  lsu_select u_select (
    .state (slot_state),
    .op    (slot_op),
    .tag   (slot_tag),
    .addr  (slot_addr),
    .value (slot_value),
    .*
  );

  l1d_port u_l1d_port (
    .l1d_req_we (l1d_req_we),
    .*
  );

endmodule : load_store_unit

// File: tb/l1d_mem_model.sv
// -------------------------------------------------------------------
// Behavioral L1D model
// Memory image, random ready and a response delay of 1 to 4 cycles
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module l1d_mem_model (
  input  logic                       clk_in,
  input  logic                       rst_N_in,
  input  logic                       hold_ready,
  input  logic                       l1d_req_valid,
  input  logic [`LSU_ADDR_WIDTH-1:0] l1d_req_addr,
  input  logic [`LSU_DATA_WIDTH-1:0] l1d_req_data,
  input  logic                       l1d_req_we,
  input  logic [`LSU_TAG_WIDTH-1:0]  l1d_req_tag,
  output logic                       l1d_req_ready,
  output logic                       l1d_resp_valid,
  output logic [`LSU_TAG_WIDTH-1:0]  l1d_resp_tag,
  output logic [`LSU_DATA_WIDTH-1:0] l1d_resp_data
);

  // Written words only, the rest read as the fill pattern
  logic [`LSU_DATA_WIDTH-1:0] mem [logic [`LSU_ADDR_WIDTH-1:0]];
  logic                       busy;
  logic [2:0]                 delay;
  logic [`LSU_TAG_WIDTH-1:0]  pend_tag;
  logic [`LSU_DATA_WIDTH-1:0] pend_data;

  // Contents of a word never written, every address bit takes part
  function automatic logic [`LSU_DATA_WIDTH-1:0] fill_word(input logic [`LSU_ADDR_WIDTH-1:0] a);
    return {a[31:0] ^ 32'h5a5a_c3c3, a[63:32] ^ {a[15:0], a[31:16]}};
  endfunction

  initial begin
    l1d_req_ready  = 1'b0;
    l1d_resp_valid = 1'b0;
    l1d_resp_tag   = '0;
    l1d_resp_data  = '0;
  end

  always @(posedge clk_in) begin
    if (!rst_N_in) begin
      l1d_req_ready  <= 1'b0;
      l1d_resp_valid <= 1'b0;
      busy           <= 1'b0;
      delay          <= '0;
    end else begin
      l1d_resp_valid <= 1'b0;
      // Ready about three cycles in four unless held off
      l1d_req_ready  <= !hold_ready && (($urandom % 4) != 0);
      if (busy) begin
        // Single-cycle response once the delay runs out
        if (delay == 3'd1) begin
          l1d_resp_valid <= 1'b1;
          l1d_resp_tag   <= pend_tag;
          l1d_resp_data  <= pend_data;
          busy           <= 1'b0;
        end
        delay <= delay - 3'd1;
      end else if (l1d_req_valid && l1d_req_ready) begin
        busy     <= 1'b1;
        delay    <= 3'(1 + ($urandom % 4));
        pend_tag <= l1d_req_tag;
        if (l1d_req_we) begin
          mem[l1d_req_addr] = l1d_req_data;
          pend_data <= '0;
        end else begin
          pend_data <= mem.exists(l1d_req_addr) ? mem[l1d_req_addr] : fill_word(l1d_req_addr);
        end
      end
    end
  end

endmodule : l1d_mem_model

// File: tb/tb_load_store_unit.sv
// -------------------------------------------------------------------
// Load-store unit testbench
// Directed tests against a program-order memory reference
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_load_store_unit;

  localparam int TAG_W   = `LSU_TAG_WIDTH;
  localparam int NTAGS   = 1 << `LSU_TAG_WIDTH;
  localparam int TIMEOUT = 500;

  logic                       clk_in;
  logic                       rst_N_in;
  logic                       instr_valid;
  logic [TAG_W-1:0]           instr_tag;
  logic                       instr_is_store;
  logic                       instr_ready;
  logic                       data_valid;
  logic [TAG_W-1:0]           data_tag;
  logic [`LSU_ADDR_WIDTH-1:0] data_addr;
  logic [`LSU_DATA_WIDTH-1:0] data_value;
  logic                       data_ready;
  logic                       cpl_valid;
  logic [TAG_W-1:0]           cpl_tag;
  logic [`LSU_DATA_WIDTH-1:0] cpl_value;
  logic                       l1d_req_valid;
  logic [`LSU_ADDR_WIDTH-1:0] l1d_req_addr;
  logic [`LSU_DATA_WIDTH-1:0] l1d_req_data;
  logic                       l1d_req_we;
  logic [TAG_W-1:0]           l1d_req_tag;
  logic                       l1d_req_ready;
  logic                       l1d_resp_valid;
  logic [TAG_W-1:0]           l1d_resp_tag;
  logic [`LSU_DATA_WIDTH-1:0] l1d_resp_data;
  logic                       hold_ready;

  // Per-tag stimulus, expectation and observed completions
  logic                       op_store  [NTAGS];
  logic [`LSU_ADDR_WIDTH-1:0] op_addr   [NTAGS];
  logic [`LSU_DATA_WIDTH-1:0] op_value  [NTAGS];
  logic [`LSU_DATA_WIDTH-1:0] exp_value [NTAGS];
  int                         cpl_count [NTAGS];
  logic [`LSU_DATA_WIDTH-1:0] cpl_data  [NTAGS];
  logic                       read_seen [NTAGS];
  // Architectural memory in program order
  logic [`LSU_DATA_WIDTH-1:0] ref_mem [logic [`LSU_ADDR_WIDTH-1:0]];
  int                         test_tags [$];
  int                         next_tag;
  int                         errors;
  int                         timeouts;

  load_store_unit UUT (.*);
  l1d_mem_model   cache (.*);

  always #2 clk_in = ~clk_in;

  // Completion and cache read monitor
  always @(posedge clk_in) begin
    if (rst_N_in && cpl_valid) begin
      cpl_count[cpl_tag] = cpl_count[cpl_tag] + 1;
      cpl_data[cpl_tag]  = cpl_value;
    end
    if (rst_N_in && l1d_req_valid && l1d_req_ready && !l1d_req_we) begin
      read_seen[l1d_req_tag] = 1'b1;
    end
  end

  // Same fill rule as the cache model
  function automatic logic [`LSU_DATA_WIDTH-1:0] initial_word(input logic [63:0] a);
    return {a[31:0] ^ 32'h5a5a_c3c3, a[63:32] ^ {a[15:0], a[31:16]}};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // New access in program order; a load expects the latest older store
  function automatic int record_op(input logic st, input logic [63:0] a, input logic [63:0] v);
    int t;
    t = next_tag;
    next_tag++;
    op_store[t] = st;
    op_addr[t]  = a;
    op_value[t] = v;
    if (st) begin
      ref_mem[a]   = v;
      exp_value[t] = '0;
    end else begin
      exp_value[t] = ref_mem.exists(a) ? ref_mem[a] : initial_word(a);
    end
    test_tags.push_back(t);
    return t;
  endfunction

  task automatic send_instr(input int t);
    int  n;
    logic ok;
    instr_valid    <= 1'b1;
    instr_tag      <= TAG_W'(t);
    instr_is_store <= op_store[t];
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
      @(posedge clk_in);
      ok = instr_ready;
      n++;
    end
    instr_valid <= 1'b0;
    if (!ok) begin
      timeouts++;
      $display("Timeout: instruction with tag %0d was never accepted", t);
    end
  endtask

  task automatic send_data(input int t);
    int  n;
    logic ok;
    data_valid <= 1'b1;
    data_tag   <= TAG_W'(t);
    data_addr  <= op_addr[t];
    data_value <= op_value[t];
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
      @(posedge clk_in);
      ok = data_ready;
      n++;
    end
    data_valid <= 1'b0;
    if (!ok) begin
      timeouts++;
      $display("Timeout: address for tag %0d was never accepted", t);
    end
  endtask

  task automatic run_op(input int t);
    send_instr(t);
    send_data(t);
  endtask

  // Waits for every access of the test, then checks single completion
  task automatic finish_ops();
    int t;
    int n;
    foreach (test_tags[i]) begin
      t = test_tags[i];
      n = 0;
      while (cpl_count[t] == 0 && n < TIMEOUT) begin
        @(posedge clk_in);
        n++;
      end
      if (cpl_count[t] == 0) begin
        timeouts++;
        $display("Timeout: no completion for tag %0d", t);
      end else begin
        compare_value($sformatf("cpl_value[tag %0d]", t), cpl_data[t], exp_value[t]);
      end
    end
    repeat (10) @(posedge clk_in);
    foreach (test_tags[i]) begin
      t = test_tags[i];
      compare_value($sformatf("cpl_count[tag %0d]", t), cpl_count[t], 1);
    end
    test_tags.delete();
  endtask

  // -------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------
  task automatic test_reset_and_basic();
    int s;
    int l;
    compare_value("instr_ready", instr_ready, 1);
    compare_value("data_ready", data_ready, 0);
    compare_value("cpl_valid", cpl_valid, 0);
    compare_value("l1d_req_valid", l1d_req_valid, 0);
    s = record_op(1'b1, 64'h1000, 64'h1111_2222_3333_4444);
    l = record_op(1'b0, 64'h1008, '0);
    send_instr(s);
    send_instr(l);
    send_data(s);
    send_data(l);
    finish_ops();
  endtask

  task automatic test_forward();
    int s;
    int l;
    s = record_op(1'b1, 64'h1010, 64'hdead_beef_0bad_f00d);
    l = record_op(1'b0, 64'h1010, '0);
    send_instr(s);
    send_instr(l);
    send_data(s);
    send_data(l);
    finish_ops();
    // Forwarded load never reaches the cache
    compare_value("l1d read of forwarded load", read_seen[l], 0);
  endtask

  task automatic test_younger_store();
    int s1;
    int s2;
    int l;
    s1 = record_op(1'b1, 64'h1018, 64'h0000_0000_aaaa_0001);
    s2 = record_op(1'b1, 64'h1018, 64'h0000_0000_bbbb_0002);
    l  = record_op(1'b0, 64'h1018, '0);
    run_op(s1);
    run_op(s2);
    run_op(l);
    finish_ops();
  endtask

  task automatic test_blocked_load();
    int s;
    int l;
    s = record_op(1'b1, 64'h1020, 64'h0123_4567_89ab_cdef);
    l = record_op(1'b0, 64'h1028, '0);
    send_instr(s);
    send_instr(l);
    send_data(l);
    // Store address still unknown, load must wait
    repeat (8) @(posedge clk_in);
    compare_value("cpl_count of blocked load", cpl_count[l], 0);
    send_data(s);
    finish_ops();
  endtask

  task automatic test_backpressure();
    int t;
    hold_ready <= 1'b1;
    repeat (2) @(posedge clk_in);
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      t = record_op(k[0], 64'h1040 + 8 * k, k[0] ? {$urandom, $urandom} : 64'h0);
      run_op(t);
    end
    @(posedge clk_in);
    compare_value("instr_ready with full queue", instr_ready, 0);
    hold_ready <= 1'b0;
    finish_ops();
  endtask

  task automatic test_random();
    logic        st;
    logic [63:0] a;
    int          t;
    for (int k = 0; k < 40; k++) begin
      st = $urandom % 2;
      a  = 64'h2000 + 8 * ($urandom % 8);
      t  = record_op(st, a, st ? {$urandom, $urandom} : 64'h0);
    end
    foreach (test_tags[i]) begin
      run_op(test_tags[i]);
    end
    finish_ops();
  endtask

  initial begin
    void'($urandom(32'hf97c6483));
    clk_in         = 1'b0;
    rst_N_in       = 1'b0;
    instr_valid    = 1'b0;
    instr_tag      = '0;
    instr_is_store = 1'b0;
    data_valid     = 1'b0;
    data_tag       = '0;
    data_addr      = '0;
    data_value     = '0;
    hold_ready     = 1'b0;
    errors         = 0;
    timeouts       = 0;
    next_tag       = 1;
    for (int i = 0; i < NTAGS; i++) begin
      cpl_count[i] = 0;
      read_seen[i] = 1'b0;
    end
    repeat (8) @(posedge clk_in);
    rst_N_in <= 1'b1;
    test_reset_and_basic();
    test_forward();
    test_younger_store();
    test_blocked_load();
    test_backpressure();
    test_random();
    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_load_store_unit

// File: src.f
+incdir+design
design/lsu_pkg.sv
design/l1d_pkg.sv
design/lsu_alloc.sv
design/lsu_slot.sv
design/lsu_select.sv
design/l1d_port.sv
design/load_store_unit.sv
tb/l1d_mem_model.sv
tb/tb_load_store_unit.sv

// File: Bender.yml
package:
  name: load_store_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_pkg.sv
      - design/l1d_pkg.sv
      - design/lsu_alloc.sv
      - design/lsu_slot.sv
      - design/lsu_select.sv
      - design/l1d_port.sv
      - design/load_store_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/l1d_mem_model.sv
      - tb/tb_load_store_unit.sv
